//--- design/tcp_rx_defs.svh
`ifndef TCP_RX_DEFS_SVH
`define TCP_RX_DEFS_SVH

// Width of one stream word in bits
// Four bytes per beat keeps the header parsing on fixed word boundaries
`define TCP_RX_DATA_W 32

// Width of the byte length fields taken from the IP and TCP headers
`define TCP_RX_LEN_W 16

// Smallest legal IPv4 header length in 32-bit words
// A smaller IHL on the wire is treated as this value
`define IPV4_MIN_IHL 5

// Smallest legal TCP data offset in 32-bit words
// The fixed part of the TCP header is always this long
`define TCP_MIN_OFFSET 5

`endif

//--- design/stream_pkg.sv
`include "tcp_rx_defs.svh"

package stream_pkg;

	// One beat on any of the word streams in the receive chain
	// The first byte on the wire sits in data[7:0]
	typedef struct packed {
		logic [`TCP_RX_DATA_W-1:0] data; // Four wire bytes in arrival order
		logic                      last; // Final word of the frame
	} word_beat_t;

	// States of the IPv4 deframer
	typedef enum logic [1:0] {
		IP_HEADER  = 2'd0, // Consuming header words including options
		IP_PAYLOAD = 2'd1, // TCP segment passes straight through
		IP_DROP    = 2'd2  // Other protocol so words are eaten until last
	} ip_state_e;

	// States of the segment summary block
	typedef enum logic {
		SUM_COLLECT = 1'b0, // Accepting payload and accumulating
		SUM_HOLD    = 1'b1  // Record presented and waiting for sum_ready
	} sum_state_e;

	// Stream handshake rule for every word_beat_t link
	// A beat moves on a clock edge where valid and ready are both high
	// and valid stays up until that happens

endpackage

//--- design/net_hdr_pkg.sv
`include "tcp_rx_defs.svh"

package net_hdr_pkg;

	typedef logic [`TCP_RX_LEN_W-1:0] len_t; // Byte length as carried in the headers

	// IP protocol numbers of interest
	typedef enum logic [7:0] {
		PROTO_ICMP = 8'd1,
		PROTO_TCP  = 8'd6,
		PROTO_UDP  = 8'd17
	} ip_proto_e;

	// Fields kept from the IPv4 header in host byte order
	typedef struct packed {
		logic [31:0] src_addr;
		logic [31:0] dst_addr;
		ip_proto_e   protocol;
		len_t        payload_len; // Total length minus the header bytes
	} ipv4_info_t;

	// Control bits of the TCP header that the design keeps
	typedef struct packed {
		logic ack;
		logic rst;
		logic syn;
		logic fin;
	} tcp_flags_t;

	// Fields kept from the TCP header in host byte order
	typedef struct packed {
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic [31:0] seq_num;
		logic [31:0] ack_num;
		tcp_flags_t  flags;
		logic [15:0] window;
		len_t        payload_len; // Segment bytes after header and options
	} tcp_hdr_t;

	// One record per TCP segment with payload
	typedef struct packed {
		tcp_hdr_t    hdr;
		logic [15:0] word_count;  // Payload words seen
		logic [15:0] payload_sum; // Ones' complement sum of host order halves
	} seg_summary_t;

	// Network fields arrive big endian while the stream puts byte 0 low
	function automatic logic [15:0] swap16(input logic [15:0] v);
		return {v[7:0], v[15:8]};
	endfunction

	function automatic logic [31:0] swap32(input logic [31:0] v);
		return {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

endpackage

//--- design/ipv4_deframer.sv
`timescale 1ns/1ps
`include "tcp_rx_defs.svh"

module ipv4_deframer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  stream_pkg::word_beat_t  in_beat,
	input  logic                    in_valid,
	output logic                    in_ready,
	output stream_pkg::word_beat_t  out_beat,
	output logic                    out_valid,
	input  logic                    out_ready,
	output net_hdr_pkg::ipv4_info_t ip_info
);
	import stream_pkg::*;
	import net_hdr_pkg::*;

	ip_state_e  state;
	logic [3:0] hdr_ctr;  // Zero based index of the current header word
	logic [3:0] ihl;      // Header length in words for the frame in progress
	logic [3:0] ihl_word; // IHL field of the current word after clamping
	logic       in_xfer;
	logic       hdr_end;

	assign in_xfer = in_valid && in_ready;

	// Short IHL values would end the header before the addresses
	assign ihl_word = (in_beat.data[3:0] < 4'(`IPV4_MIN_IHL)) ?
		4'(`IPV4_MIN_IHL) : in_beat.data[3:0];

	// The stored ihl is never below the minimum so word 0 cannot match here
	assign hdr_end = (state == IP_HEADER) && (hdr_ctr == ihl - 4'd1);

	// Data passes through untouched and only the handshake depends on state
	assign out_beat = in_beat;

	always_comb
	begin
		case (state)
			IP_PAYLOAD:
			begin
				in_ready  = out_ready; // Zero latency pass through
				out_valid = in_valid;
			end
			default:
			begin
				in_ready  = 1'b1; // Header and dropped words are always taken
				out_valid = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= IP_HEADER;
			hdr_ctr <= 4'd0;
			ihl     <= 4'(`IPV4_MIN_IHL);
		end
		else if (in_xfer)
		begin
			case (state)
				IP_HEADER:
				begin
					if (hdr_ctr == 4'd0)
						ihl <= ihl_word; // Header length for this frame
					if (in_beat.last)
					begin
						hdr_ctr <= 4'd0; // Frame ended inside its header
						state   <= IP_HEADER;
					end
					else if (hdr_end)
					begin
						hdr_ctr <= 4'd0;
						// Protocol was captured two or more words earlier
						state   <= (ip_info.protocol == PROTO_TCP) ? IP_PAYLOAD : IP_DROP;
					end
					else
						hdr_ctr <= hdr_ctr + 4'd1;
				end
				IP_PAYLOAD, IP_DROP:
				begin
					if (in_beat.last)
						state <= IP_HEADER; // Next word starts a new packet
				end
				default: state <= IP_HEADER;
			endcase
		end
	end

	// Header fields are captured as their words go by
	always_ff @(posedge clk)
	begin
		if (in_xfer && (state == IP_HEADER))
		begin
			case (hdr_ctr)
				// Total length sits in bytes 2 and 3 of word 0
				4'd0: ip_info.payload_len <= swap16(in_beat.data[31:16]) - (len_t'(ihl_word) << 2);
				4'd2: ip_info.protocol <= ip_proto_e'(in_beat.data[15:8]);
				4'd3: ip_info.src_addr <= swap32(in_beat.data);
				4'd4: ip_info.dst_addr <= swap32(in_beat.data);
				default: ; // TOS, ident, TTL, checksum and options are not kept
			endcase
		end
	end

endmodule

//--- design/tcp_deframer.sv
`timescale 1ns/1ps
`include "tcp_rx_defs.svh"

module tcp_deframer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  stream_pkg::word_beat_t    in_beat,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  logic [`TCP_RX_LEN_W-1:0]  ip_payload_len, // From the IPv4 deframer
	output stream_pkg::word_beat_t    out_beat,
	output logic                      out_valid,
	input  logic                      out_ready,
	output net_hdr_pkg::tcp_hdr_t     tcp_hdr
);
	import net_hdr_pkg::*;

	logic [3:0] off_ctr;     // Zero based header word counter
	logic [3:0] data_offset; // Last header word index so offset minus one
	logic [3:0] off_word;    // Offset field of the current word after clamping
	logic       in_xfer;
	logic       hdr_done;

	assign in_xfer = in_valid && in_ready;

	// Offsets under the fixed header size are read as the minimum
	assign off_word = (in_beat.data[7:4] < 4'(`TCP_MIN_OFFSET)) ?
		4'(`TCP_MIN_OFFSET) : in_beat.data[7:4];

	// Counter runs one past the last header word and then parks there
	// Reset leaves data_offset at 15 so words 0 to 3 are always counted
	assign hdr_done = (off_ctr > data_offset);

	assign in_ready  = hdr_done ? out_ready : 1'b1; // Header words go unconditionally
	assign out_valid = hdr_done ? in_valid : 1'b0;
	assign out_beat  = in_beat;                    // Last flag rides along unchanged

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			off_ctr     <= 4'd0;
			data_offset <= '1;
		end
		else if (in_xfer && in_beat.last)
		begin
			off_ctr     <= 4'd0; // Ready for the next segment
			data_offset <= '1;
		end
		else if (in_xfer)
		begin
			if (off_ctr <= data_offset)
				off_ctr <= off_ctr + 4'd1;
			if (off_ctr == 4'd3)
				data_offset <= off_word - 4'd1;
		end
	end

	// Captured fields stay put through the payload for the summary block
	always_ff @(posedge clk)
	begin
		if (in_xfer)
		begin
			case (off_ctr)
				4'd0:
				begin
					tcp_hdr.src_port <= swap16(in_beat.data[15:0]);
					tcp_hdr.dst_port <= swap16(in_beat.data[31:16]);
				end
				4'd1: tcp_hdr.seq_num <= swap32(in_beat.data);
				4'd2: tcp_hdr.ack_num <= swap32(in_beat.data);
				4'd3:
				begin
					// Payload bytes left once header and options are removed
					tcp_hdr.payload_len <= ip_payload_len - (len_t'(off_word) << 2);
					tcp_hdr.flags.ack   <= in_beat.data[11];
					tcp_hdr.flags.rst   <= in_beat.data[10];
					tcp_hdr.flags.syn   <= in_beat.data[9];
					tcp_hdr.flags.fin   <= in_beat.data[8];
					tcp_hdr.window      <= swap16(in_beat.data[31:16]);
				end
				default: ; // Checksum, urgent pointer, options and payload
			endcase
		end
	end

endmodule

//--- design/tcp_segment_summary.sv
`timescale 1ns/1ps

module tcp_segment_summary (
	input  logic                      clk,
	input  logic                      rst_n,
	input  stream_pkg::word_beat_t    in_beat,
	input  logic                      in_valid,
	output logic                      in_ready,
	input  net_hdr_pkg::tcp_hdr_t     tcp_hdr,
	output net_hdr_pkg::seg_summary_t sum,
	output logic                      sum_valid,
	input  logic                      sum_ready
);
	import stream_pkg::*;
	import net_hdr_pkg::*;

	sum_state_e  state;
	logic [15:0] word_cnt; // Payload words accepted so far in this segment
	logic [15:0] acc;      // Running ones' complement sum
	logic [15:0] next_acc; // Sum including the current beat
	logic        in_xfer;

	// 16-bit ones' complement addition with the carry folded back in
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]}; // Cannot carry out a second time
	endfunction

	assign in_ready  = (state == SUM_COLLECT);
	assign in_xfer   = in_valid && in_ready;
	assign sum_valid = (state == SUM_HOLD); // Rises the cycle after the last beat

	// Both halves are taken in host order before adding
	assign next_acc = ones_add(ones_add(acc, swap16(in_beat.data[15:0])),
		swap16(in_beat.data[31:16]));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= SUM_COLLECT;
			word_cnt <= 16'd0;
			acc      <= 16'd0;
		end
		else
		begin
			case (state)
				SUM_COLLECT:
				begin
					if (in_xfer)
					begin
						word_cnt <= word_cnt + 16'd1;
						acc      <= next_acc;
						if (in_beat.last)
							state <= SUM_HOLD; // Record is loaded on this same edge
					end
				end
				SUM_HOLD:
				begin
					// Input stays stalled until the record is taken
					if (sum_ready)
					begin
						state    <= SUM_COLLECT;
						word_cnt <= 16'd0;
						acc      <= 16'd0;
					end
				end
				default: state <= SUM_COLLECT;
			endcase
		end
	end

	// Record register holds steady through SUM_HOLD since no beat is accepted there
	always_ff @(posedge clk)
	begin
		if (in_xfer && in_beat.last)
		begin
			sum.hdr         <= tcp_hdr; // Stable since the TCP header ended
			sum.word_count  <= word_cnt + 16'd1;
			sum.payload_sum <= next_acc;
		end
	end

endmodule

//--- design/tcp_rx_top.sv
`timescale 1ns/1ps

module tcp_rx_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  stream_pkg::word_beat_t    in_beat,
	input  logic                      in_valid,
	output logic                      in_ready,
	output net_hdr_pkg::seg_summary_t sum,
	output logic                      sum_valid,
	input  logic                      sum_ready
);
	import stream_pkg::*;
	import net_hdr_pkg::*;

	word_beat_t ip_seg;        // TCP segment with the IPv4 header removed
	logic       ip_seg_valid;
	logic       ip_seg_ready;
	ipv4_info_t ip_info;
	word_beat_t payload;       // Segment payload with the TCP header removed
	logic       payload_valid;
	logic       payload_ready;
	tcp_hdr_t   tcp_hdr;

	ipv4_deframer u_ipv4 (
		.clk(clk), .rst_n(rst_n),
		.in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
		.out_beat(ip_seg), .out_valid(ip_seg_valid), .out_ready(ip_seg_ready),
		.ip_info(ip_info)
	);

	// Only the payload length of the IPv4 fields feeds the next stage
	tcp_deframer u_tcp (
		.clk(clk), .rst_n(rst_n),
		.in_beat(ip_seg), .in_valid(ip_seg_valid), .in_ready(ip_seg_ready),
		.ip_payload_len(ip_info.payload_len),
		.out_beat(payload), .out_valid(payload_valid), .out_ready(payload_ready),
		.tcp_hdr(tcp_hdr)
	);

	tcp_segment_summary u_summary (
		.clk(clk), .rst_n(rst_n),
		.in_beat(payload), .in_valid(payload_valid), .in_ready(payload_ready),
		.tcp_hdr(tcp_hdr),
		.sum(sum), .sum_valid(sum_valid), .sum_ready(sum_ready)
	);

endmodule

//--- testbench/tcp_rx_tb.sv
`timescale 1ns/1ps
`include "tcp_rx_defs.svh"

module tcp_rx_tb;
	import stream_pkg::*;
	import net_hdr_pkg::*;

	localparam int PAT_DEPTH = 512;
	localparam logic [`TCP_RX_DATA_W-1:0] TAG_WORD = 'h0; // Input word entry
	localparam logic [`TCP_RX_DATA_W-1:0] TAG_EXP  = 'h1; // Expected summary entry
	localparam logic [`TCP_RX_DATA_W-1:0] TAG_END  = 'h2; // End of the pattern data

	logic         clk;
	logic         rst_n;
	word_beat_t   in_beat;
	logic         in_valid;
	logic         in_ready;
	seg_summary_t sum;
	logic         sum_valid;
	logic         sum_ready;

	logic [`TCP_RX_DATA_W-1:0] pat_mem [0:PAT_DEPTH-1];
	word_beat_t   in_words[$]; // Every word of every frame in wire order
	seg_summary_t exp_q[$];    // Records still to be received
	int           in_idx;      // Index of the word currently presented
	int           seg_idx;
	int           mismatch_count;
	int           fail_count;
	int           cycles;
	int           limit;
	integer       seed;
	integer       rnd;

	tcp_rx_top UUT (
		.clk(clk), .rst_n(rst_n),
		.in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
		.sum(sum), .sum_valid(sum_valid), .sum_ready(sum_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Splits the flat hex memory into input beats and expected records
	task automatic load_patterns();
		int           i;
		word_beat_t   beat;
		seg_summary_t rec;
		i = 0;
		$readmemh("testbench/tcp_rx_patterns.txt", pat_mem);
		while (i < PAT_DEPTH && pat_mem[i] !== TAG_END)
		begin
			if (pat_mem[i] === TAG_WORD)
			begin
				beat.last = pat_mem[i+1][0];
				beat.data = pat_mem[i+2];
				in_words.push_back(beat);
				i += 3;
			end
			else if (pat_mem[i] === TAG_EXP)
			begin
				rec.hdr.src_port    = pat_mem[i+1][15:0];
				rec.hdr.dst_port    = pat_mem[i+2][15:0];
				rec.hdr.seq_num     = pat_mem[i+3];
				rec.hdr.ack_num     = pat_mem[i+4];
				rec.hdr.flags       = tcp_flags_t'(pat_mem[i+5][3:0]); // Ack, rst, syn, fin
				rec.hdr.window      = pat_mem[i+6][15:0];
				rec.hdr.payload_len = pat_mem[i+7][15:0];
				rec.word_count      = pat_mem[i+8][15:0];
				rec.payload_sum     = pat_mem[i+9][15:0];
				exp_q.push_back(rec);
				i += 10;
			end
			else
			begin
				$display("Pattern file holds an unknown tag at entry %0d", i);
				fail_count++;
				i = PAT_DEPTH;
			end
		end
	endtask

	task automatic compare_tcp_hdr(input string name, input tcp_hdr_t expected,
		input tcp_hdr_t actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s header expected %h %h %h %h %b %h %h actual %h %h %h %h %b %h %h",
				name, expected.src_port, expected.dst_port, expected.seq_num, expected.ack_num,
				expected.flags, expected.window, expected.payload_len, actual.src_port,
				actual.dst_port, actual.seq_num, actual.ack_num, actual.flags, actual.window,
				actual.payload_len);
			mismatch_count++;
		end
	endtask

	task automatic compare_payload_stats(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// Single handshake bits such as in_ready and sum_valid
	task automatic compare_handshake(input string name, input logic expected,
		input logic actual);
		if (actual !== expected)
		begin
			$display("MISMATCH %s expected %b actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	// Pairs each accepted record with the oldest expected one
	task automatic check_summary(input seg_summary_t actual);
		seg_summary_t expected;
		string        name;
		name = $sformatf("segment %0d", seg_idx);
		seg_idx++;
		if (exp_q.size() == 0)
		begin
			$display("Summary for %s arrived but no expected record is left", name);
			fail_count++;
		end
		else
		begin
			expected = exp_q.pop_front();
			compare_tcp_hdr(name, expected.hdr, actual.hdr);
			compare_payload_stats({name, " word_count"}, expected.word_count, actual.word_count);
			compare_payload_stats({name, " payload_sum"}, expected.payload_sum, actual.payload_sum);
		end
	endtask

	// Frames go out back to back and the next word follows each transfer
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (in_valid && in_ready)
				in_idx = in_idx + 1;
			if (in_idx < in_words.size())
			begin
				in_beat  <= in_words[in_idx];
				in_valid <= 1'b1;
			end
			else
				in_valid <= 1'b0; // All words sent
		end
	end

	// Random sum_ready stalls the summary and through it the payload path
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (sum_valid && sum_ready)
				check_summary(sum);
			rnd = $random(seed);
			sum_ready <= rnd[0];
		end
	end

	initial
	begin
		seed           = 59;
		rst_n          = 1'b0;
		in_beat        = '0;
		in_valid       = 1'b0;
		sum_ready      = 1'b0;
		in_idx         = 0;
		seg_idx        = 0;
		mismatch_count = 0;
		fail_count     = 0;
		cycles         = 0;
		load_patterns();
		if (in_words.size() == 0)
		begin
			$display("No input words were loaded from the pattern file");
			fail_count++;
		end
		limit = in_words.size() * 4 + exp_q.size() * 8 + 200; // Generous for half rate sum_ready
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk); // First cycle out of reset
		compare_handshake("reset in_ready", 1'b1, in_ready);
		compare_handshake("reset sum_valid", 1'b0, sum_valid);
		while ((in_idx < in_words.size() || exp_q.size() != 0) && cycles < limit)
		begin
			@(negedge clk); // Outputs are settled here
			cycles++;
		end
		repeat (16) @(negedge clk); // Room for a stray record after the last one
		if (cycles >= limit)
		begin
			$display("Timeout after %0d cycles with %0d of %0d input words sent",
				cycles, in_idx, in_words.size());
			fail_count++;
		end
		if (exp_q.size() != 0)
		begin
			$display("%0d expected summary records were never received", exp_q.size());
			fail_count++;
		end
		$display("Mismatches %0d, other failures %0d", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- tcp_rx.f
+incdir+design
design/stream_pkg.sv
design/net_hdr_pkg.sv
design/ipv4_deframer.sv
design/tcp_deframer.sv
design/tcp_segment_summary.sv
design/tcp_rx_top.sv
testbench/tcp_rx_tb.sv

//--- testbench/tcp_rx_patterns.txt
// Input word: 0 <last> <data with the first wire byte in bits 7:0>
// Expected: 1 <src_port> <dst_port> <seq> <ack> <flags ack,rst,syn,fin> <window> <payload_len> <word_count> <payload_sum>, then 2 ends the data
0 0 2c000045 // TCP SYN with IHL 5 and offset 5 and one payload word
0 0 00000000
0 0 00000640
0 0 0100a8c0
0 0 0200a8c0
0 0 5000901f
0 0 44332211
0 0 88776655
0 0 f0fa0250
0 0 00000000
0 1 04030201
1 1f90 0050 11223344 55667788 2 faf0 0004 0001 0406
0 0 18000045 // UDP packet that is dropped
0 0 00000000
0 0 00001140
0 0 0100a8c0
0 0 0200a8c0
0 1 35003500
0 0 14000045 // ICMP packet ending inside its header
0 0 00000000
0 0 00000140
0 0 0100a8c0
0 1 0200a8c0
0 0 3a000046 // TCP SYN+ACK with IHL 6 and offset 7 and six payload bytes
0 0 00000000
0 0 00000640
0 0 0100a8c0
0 0 0200a8c0
0 0 00000494
0 0 bb0150c3
0 0 efbeadde
0 0 01000000
0 0 10720a70
0 0 00000000
0 0 b4050402
0 0 02040101
0 0 4030eeff
0 1 00006050
1 c350 01bb deadbeef 00000001 a 7210 0006 0002 808f
0 0 30000045 // TCP FIN+ACK with two payload words and an end-around carry
0 0 00000000
0 0 00000640
0 0 0100a8c0
0 0 0200a8c0
0 0 901f5000
0 0 89776655
0 0 49332211
0 0 00020950
0 0 00000000
0 0 ffffffff
0 1 02000100
1 0050 1f90 55667789 11223349 9 0200 0008 0002 0003
0 0 2b000045 // TCP RST with three payload bytes padded to one word
0 0 00000000
0 0 00000640
0 0 0100a8c0
0 0 0200a8c0
0 0 16000004
0 0 00000080
0 0 ffff0000
0 0 00000450
0 0 00000000
0 1 00563412
1 0400 0016 80000000 0000ffff 4 0000 0003 0001 6834
2
